// File: nono_testdata.txt
# tags: B byte | D n m | W addr word | L line base count, all hex
# board 1 is 3 columns by 2 rows, lines 0..1 rows and 2..4 columns
B e0 B 06 B e0 B 04
B c0 B 00 B a0 B 01 B a0 B 03 B a0 B 05 B 20 B 00
B c0 B 00 B a0 B 01 B 40 B 00 B a0 B 03 B 40 B 00 B a0 B 05 B 20 B 00
B c0 B 00 B a0 B 01 B a0 B 03 B 20 B 00
B c0 B 00 B a0 B 01 B 40 B 00 B a0 B 03 B 20 B 00
B c0 B 00 B a0 B 01 B a0 B 03 B a0 B 00 B 20 B 00
B 00 B 00
D 3 2
W 000 8000 W 001 0007 W 002 8001 W 003 0001
W 004 0002 W 005 0004 W 006 8002 W 007 0003
W 008 8003 W 009 0001 W 00a 0002 W 00b 8004 W 00c 0002
L 0 000 1 L 1 002 3 L 2 006 1 L 3 008 2 L 4 00b 1
# board 2 is 2 columns by 1 row, it overwrites board 1 from address 0
B e0 B 04 B e0 B 02
B c0 B 00 B a0 B 01 B 40 B 00 B a0 B 03 B 20 B 00
B c0 B 00 B a0 B 01 B 20 B 00
B c0 B 00 B a0 B 00 B 20 B 00
B 00 B 00
D 2 1
W 000 8000 W 001 0001 W 002 0002 W 003 8001
W 004 0001 W 005 8002 W 006 0000
L 0 000 2 L 1 003 1 L 2 005 1

// File: vlog.f
+incdir+.
nono_pkg.sv
byte_ingress.sv
board_parser.sv
line_table.sv
option_mem.sv
nono_top.sv
nono_assert.sv
tb_nono.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_nono -f vlog.f -o tb_nono_sim

out=$(./obj_dir/tb_nono_sim 2>&1) || true
echo "$out"

if grep -qx "=== PASS ===" <<< "$out"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb_nono.sv
`timescale 1ns/1ps
`default_nettype none

`include "nono_params.svh"

module tb_nono;

    localparam int CREDITS = `NONO_BYTE_CREDITS;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic  [7:0] in_byte;
    logic        in_credit;
    logic        board_done;
    logic  [3:0] board_n;
    logic  [3:0] board_m;
    logic  [8:0] rd_addr;
    logic [15:0] rd_word;
    logic  [4:0] line_sel;
    logic  [8:0] line_base;
    logic  [6:0] line_count;
    logic        line_is_row;

    logic  [7:0] rec_tag [$];   // one entry per record of the data file
    int          rec_a [$];
    int          rec_b [$];
    int          rec_c [$];
    int          num_bytes;
    int          cycle_limit;
    int          cycles = 0;
    int          credits_back;  // credit pulses seen from the DUT
    int          bytes_sent;
    int          boards_done;
    int          boards_sent;
    int          exp_m;
    logic        pending;       // bytes went out since the last board finished

    nono_top u_nono_top (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_byte     (in_byte),
        .in_credit   (in_credit),
        .board_done  (board_done),
        .board_n     (board_n),
        .board_m     (board_m),
        .rd_addr     (rd_addr),
        .rd_word     (rd_word),
        .line_sel    (line_sel),
        .line_base   (line_base),
        .line_count  (line_count),
        .line_is_row (line_is_row)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // credit returns and finished boards
    always @(posedge clk) begin
        if (rst) begin
            credits_back <= 0;
            boards_done  <= 0;
        end else begin
            if (in_credit) credits_back <= credits_back + 1;
            if (board_done) boards_done <= boards_done + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: board never finished within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_records();
        int                 fd;
        int                 n;
        int                 a;
        int                 b;
        int                 c;
        logic [8*8-1:0]     tag;
        logic [8*120-1:0]   rest;
        fd = $fopen("nono_testdata.txt", "r");
        num_bytes = 0;
        if (fd == 0) begin
            $display("could not open nono_testdata.txt");
            $display("=== FAIL ===");
            $fatal(1, "missing data file");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                a = 0;
                b = 0;
                c = 0;
                case (tag[7:0])
                    "#": n = $fgets(rest, fd) > 0 ? 1 : 0;   // comment line
                    "B": n = $fscanf(fd, "%h", a) - 1;
                    "D": n = $fscanf(fd, "%h %h", a, b) - 2;
                    "W": n = $fscanf(fd, "%h %h", a, b) - 2;
                    "L": n = $fscanf(fd, "%h %h %h", a, b, c) - 3;
                    default: n = -1;
                endcase
                if (n != 0 && tag[7:0] != "#") begin
                    $display("malformed record in nono_testdata.txt");
                    $display("=== FAIL ===");
                    $fatal(1, "bad data file");
                end else if (tag[7:0] != "#") begin
                    rec_tag.push_back(tag[7:0]);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                    rec_c.push_back(c);
                    if (tag[7:0] == "B") num_bytes++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_byte(input logic [7:0] b, input logic burst);
        int gap;
        int held;
        gap = burst ? 0 : int'($urandom % 3);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        // host may only send while it owns a credit
        while (bytes_sent - credits_back >= CREDITS) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_byte  = b;
        bytes_sent++;
        held = CREDITS - bytes_sent + credits_back;
        check_val("credits in range", 32'(held >= 0 && held <= CREDITS), 32'd1);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // wait for board_done of the board just streamed
    task automatic settle_board();
        if (pending) begin
            boards_sent++;
            pending = 1'b0;
            while (boards_done < boards_sent) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // lines beyond the n + m lines of the board keep a zero count
    task automatic check_unused_lines(input int first);
        for (int ln = first; ln < `NONO_MAX_LINES; ln++) begin
            line_sel = 5'(ln);
            @(posedge clk);
            #1;
            check_val("line_count", 32'(line_count), 32'd0);
        end
    endtask

    initial begin
        void'($urandom(94));
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_byte     = 8'h00;
        rd_addr     = 9'd0;
        line_sel    = 5'd0;
        bytes_sent  = 0;
        boards_sent = 0;
        exp_m       = 0;
        pending     = 1'b0;
        cycle_limit = 1000;
        load_records();
        cycle_limit = 20 * num_bytes + 200;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < rec_tag.size(); i++) begin
            case (rec_tag[i])
                "B": begin
                    send_byte(rec_a[i][7:0], boards_sent == 1);   // second board in bursts
                    pending = 1'b1;
                end
                "D": begin
                    settle_board();
                    check_val("board_n", 32'(board_n), rec_a[i]);
                    check_val("board_m", 32'(board_m), rec_b[i]);
                    exp_m = rec_b[i];
                    check_unused_lines(rec_a[i] + rec_b[i]);
                end
                "W": begin
                    settle_board();
                    rd_addr = rec_a[i][8:0];
                    @(posedge clk);
                    #1;
                    check_val("rd_word", 32'(rd_word), rec_b[i]);
                end
                default: begin
                    settle_board();
                    line_sel = rec_a[i][4:0];
                    @(posedge clk);
                    #1;
                    check_val("line_base", 32'(line_base), rec_b[i]);
                    check_val("line_count", 32'(line_count), rec_c[i]);
                    check_val("line_is_row", 32'(line_is_row), 32'(rec_a[i] < exp_m));
                end
            endcase
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: nono_assert.sv
`timescale 1ns/1ps
`default_nettype none

module nono_assert (
    input wire clk,
    input wire rst,
    input wire wr_req,      // byte arriving at the FIFO
    input wire fifo_full,
    input wire fifo_pop,
    input wire wr_en,
    input wire board_done
);

    // the credit contract keeps the FIFO from overflowing
    no_full_write: assert property (
        @(posedge clk) disable iff (rst) !(wr_req && fifo_full)
    ) else $error("byte written into a full FIFO");

    done_one_cycle: assert property (
        @(posedge clk) disable iff (rst) board_done |=> !board_done
    ) else $error("board_done held longer than one cycle");

    wr_after_pop: assert property (
        @(posedge clk) disable iff (rst) $rose(wr_en) |-> $past(fifo_pop)
    ) else $error("word write without a pop in the cycle before");

endmodule

// ingress side, parser ports tied low
bind byte_ingress nono_assert u_ingress_assert (
    .clk        (clk),
    .rst        (rst),
    .wr_req     (in_valid_q),
    .fifo_full  (full),
    .fifo_pop   (fifo_pop),
    .wr_en      (1'b0),
    .board_done (1'b0)
);

bind board_parser nono_assert u_parser_assert (
    .clk        (clk),
    .rst        (rst),
    .wr_req     (1'b0),
    .fifo_full  (1'b0),
    .fifo_pop   (fifo_pop),
    .wr_en      (wr_en),
    .board_done (board_done)
);

`default_nettype wire

// File: nono_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "nono_params.svh"

module nono_top
    import nono_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         in_valid,
    input  wire   [7:0] in_byte,
    output logic        in_credit,
    output logic        board_done,
    output logic  [3:0] board_n,
    output logic  [3:0] board_m,
    input  wire   [8:0] rd_addr,
    output logic [15:0] rd_word,
    input  wire   [4:0] line_sel,
    output logic  [8:0] line_base,
    output logic  [6:0] line_count,
    output logic        line_is_row
);

    logic                    fifo_valid;
    logic              [7:0] fifo_byte;
    logic                    fifo_pop;
    logic                    wr_en;
    logic [`NONO_WORD_W-1:0] wr_word;
    word_kind_e              wr_kind;
    logic [`NONO_ADDR_W-1:0] wr_addr;

    byte_ingress u_byte_ingress (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_byte    (in_byte),
        .in_credit  (in_credit),
        .fifo_valid (fifo_valid),
        .fifo_byte  (fifo_byte),
        .fifo_pop   (fifo_pop)
    );

    board_parser u_board_parser (
        .clk        (clk),
        .rst        (rst),
        .fifo_valid (fifo_valid),
        .fifo_byte  (fifo_byte),
        .fifo_pop   (fifo_pop),
        .wr_en      (wr_en),
        .wr_word    (wr_word),
        .wr_kind    (wr_kind),
        .board_done (board_done),
        .board_n    (board_n),
        .board_m    (board_m)
    );

    option_mem u_option_mem (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_word (wr_word),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    // table follows the memory's own write address
    line_table u_line_table (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_kind     (wr_kind),
        .wr_addr     (wr_addr),
        .board_m     (board_m),
        .line_sel    (line_sel),
        .line_base   (line_base),
        .line_count  (line_count),
        .line_is_row (line_is_row)
    );

endmodule

`default_nettype wire

// File: option_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "nono_params.svh"

module option_mem (
    input  wire         clk,
    input  wire         rst,
    input  wire         wr_en,
    input  wire  [15:0] wr_word,
    output logic  [8:0] wr_addr,
    input  wire   [8:0] rd_addr,
    output logic [15:0] rd_word
);

    localparam int DEPTH  = `NONO_MEM_DEPTH;
    localparam int ADDR_W = `NONO_ADDR_W;
    localparam int WORD_W = `NONO_WORD_W;

    logic [WORD_W-1:0] mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;    // append pointer
    logic              restart;

    // header of line 0 starts a new board back at address 0
    assign restart = (wr_word == `NONO_HDR_TAG);
    assign wr_addr = restart ? '0 : wr_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_addr + 1'b1;
        end
    end

    // plain RAM, registered read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
        rd_word <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: line_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "nono_params.svh"

module line_table
    import nono_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        wr_en,
    input  word_kind_e wr_kind,
    input  wire  [8:0] wr_addr,
    input  wire  [3:0] board_m,
    input  wire  [4:0] line_sel,
    output logic [8:0] line_base,
    output logic [6:0] line_count,
    output logic       line_is_row
);

    localparam int LINES  = `NONO_MAX_LINES;
    localparam int LINE_W = `NONO_LINE_W;
    localparam int CNT_W  = `NONO_CNT_W;
    localparam int ADDR_W = `NONO_ADDR_W;

    logic [ADDR_W-1:0] base  [LINES];
    logic  [CNT_W-1:0] count [LINES];
    logic [LINE_W-1:0] cur_line;
    logic [LINE_W-1:0] hdr_line;
    logic              new_board;
    logic              hdr_wr;
    logic              sel_ok;

    // only the line 0 header of a board lands on address 0
    assign new_board = (wr_addr == '0);
    assign hdr_wr    = wr_en && (wr_kind == WK_HEADER);
    assign hdr_line  = new_board ? '0 : cur_line + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_line <= '0;
            for (int i = 0; i < LINES; i++) begin
                count[i] <= '0;
            end
        end else if (hdr_wr) begin
            if (new_board) begin
                for (int i = 0; i < LINES; i++) begin
                    count[i] <= '0;
                end
            end
            cur_line <= hdr_line;
            if (32'(hdr_line) < LINES) begin
                count[hdr_line] <= '0;
            end
        end else if (wr_en && 32'(cur_line) < LINES) begin
            if (count[cur_line] != CNT_W'(`NONO_MAX_OPTS)) begin  // saturate
                count[cur_line] <= count[cur_line] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_wr && 32'(hdr_line) < LINES) begin
            base[hdr_line] <= wr_addr;
        end
    end

    // read side is combinational
    assign sel_ok      = (32'(line_sel) < LINES);
    assign line_base   = sel_ok ? base[line_sel] : '0;
    assign line_count  = sel_ok ? count[line_sel] : '0;
    assign line_is_row = (line_sel < 5'(board_m));   // rows come first

endmodule

`default_nettype wire

// File: board_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "nono_params.svh"

module board_parser
    import nono_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         fifo_valid,
    input  wire   [7:0] fifo_byte,
    output logic        fifo_pop,
    output logic        wr_en,
    output logic [15:0] wr_word,
    output word_kind_e  wr_kind,
    output logic        board_done,
    output logic  [3:0] board_n,
    output logic  [3:0] board_m
);

    localparam int WORD_W  = `NONO_WORD_W;
    localparam int LINE_W  = `NONO_LINE_W;
    // longest line on any legal board
    localparam int MAX_LEN = (`NONO_MAX_ROWS > `NONO_MAX_COLS) ?
                             `NONO_MAX_ROWS : `NONO_MAX_COLS;

    parse_state_e      state;
    msg_flag_e         flag_q;       // flag of the message in progress
    logic              size_second;  // next START_BOARD carries m
    logic [LINE_W-1:0] line_idx;
    logic [WORD_W-1:0] cur_opt;      // option being assembled by AND messages
    logic        [4:0] size_field;
    logic        [3:0] bit_idx;

    assign fifo_pop   = fifo_valid;  // one byte per cycle, no stall
    assign size_field = fifo_byte[5:1];
    assign bit_idx    = fifo_byte[4:1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= PS_FLAG;
            wr_en       <= 1'b0;
            board_done  <= 1'b0;
            size_second <= 1'b0;
            line_idx    <= '0;
            board_n     <= '0;
            board_m     <= '0;
        end else begin
            wr_en      <= 1'b0;
            board_done <= 1'b0;
            if (fifo_pop) begin
                case (state)
                    PS_FLAG: begin
                        state <= PS_PAYLOAD;
                    end
                    PS_PAYLOAD: begin
                        state <= PS_FLAG;
                        case (flag_q)
                            FLAG_START_BOARD: begin
                                // first one is n (columns), second one is m (rows)
                                if (!size_second) begin
                                    board_n <= (size_field > 5'(`NONO_MAX_COLS)) ?
                                               4'(`NONO_MAX_COLS) : size_field[3:0];
                                end else begin
                                    board_m <= (size_field > 5'(`NONO_MAX_ROWS)) ?
                                               4'(`NONO_MAX_ROWS) : size_field[3:0];
                                end
                                size_second <= !size_second;
                                line_idx    <= '0;
                            end
                            FLAG_START_LINE: begin
                                wr_en <= 1'b1;
                            end
                            FLAG_OR: begin
                                wr_en <= 1'b1;
                            end
                            FLAG_END_LINE: begin
                                wr_en    <= 1'b1;
                                line_idx <= line_idx + 1'b1;
                            end
                            FLAG_END_BOARD: begin
                                board_done <= 1'b1;
                            end
                            default: begin
                                // AND and unknown flags write nothing
                            end
                        endcase
                    end
                    default: state <= PS_FLAG;
                endcase
            end
        end
    end

    // word payload and the option under construction
    always_ff @(posedge clk) begin
        if (fifo_pop && state == PS_FLAG) begin
            flag_q <= msg_flag_e'(fifo_byte[7:5]);
        end
        if (fifo_pop && state == PS_PAYLOAD) begin
            case (flag_q)
                FLAG_START_BOARD: begin
                    cur_opt <= '0;
                end
                FLAG_START_LINE: begin
                    wr_word <= `NONO_HDR_TAG | WORD_W'(line_idx);
                    wr_kind <= WK_HEADER;
                    cur_opt <= '0;
                end
                FLAG_AND: begin
                    if (32'(bit_idx) < MAX_LEN) begin  // cells past any line are dropped
                        cur_opt[bit_idx] <= fifo_byte[0];
                    end
                end
                FLAG_OR, FLAG_END_LINE: begin
                    wr_word <= cur_opt;
                    wr_kind <= WK_OPTION;
                    cur_opt <= '0;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: byte_ingress.sv
`timescale 1ns/1ps
`default_nettype none

`include "nono_params.svh"

module byte_ingress (
    input  wire        clk,
    input  wire        rst,
    input  wire        in_valid,
    input  wire  [7:0] in_byte,
    output logic       in_credit,
    output logic       fifo_valid,
    output logic [7:0] fifo_byte,
    input  wire        fifo_pop
);

    localparam int DEPTH = `NONO_BYTE_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic             in_valid_q;   // input stage, host byte lands here first
    logic [7:0]       in_byte_q;
    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == CNT_W'(DEPTH));
    assign push = in_valid_q && !full;   // full never happens while the host keeps to its credits
    assign pop  = fifo_pop && fifo_valid;

    assign fifo_valid = (count != '0);
    assign fifo_byte  = mem[rd_ptr];      // first word fall-through
    assign in_credit  = pop;              // every byte leaving hands one credit back

    always_ff @(posedge clk) begin
        if (rst) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        in_byte_q <= in_byte;
        if (push) begin
            mem[wr_ptr] <= in_byte_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: nono_pkg.sv
`default_nettype none

package nono_pkg;

    // flag in bits 7..5 of the first byte of each message
    typedef enum logic [2:0] {
        FLAG_END_BOARD   = 3'b000,
        FLAG_END_LINE    = 3'b001,
        FLAG_OR          = 3'b010,
        FLAG_AND         = 3'b101,
        FLAG_START_LINE  = 3'b110,
        FLAG_START_BOARD = 3'b111
    } msg_flag_e;

    // which byte of a message comes next
    typedef enum logic [1:0] {
        PS_FLAG    = 2'd0,
        PS_PAYLOAD = 2'd1
    } parse_state_e;

    typedef enum logic {
        WK_HEADER = 1'b0,   // opens a line
        WK_OPTION = 1'b1    // one option of the current line
    } word_kind_e;

endpackage

`default_nettype wire

// File: nono_params.svh
`ifndef NONO_PARAMS_SVH
`define NONO_PARAMS_SVH

// board limits
`define NONO_MAX_ROWS 11
`define NONO_MAX_COLS 11
`define NONO_MAX_LINES (`NONO_MAX_ROWS + `NONO_MAX_COLS)
`define NONO_LINE_W $clog2(`NONO_MAX_LINES)

// options per line, 9 choose 3 at most
`define NONO_MAX_OPTS 84
`define NONO_CNT_W $clog2(`NONO_MAX_OPTS + 1)

// option memory
`define NONO_WORD_W 16
`define NONO_MEM_DEPTH 512
`define NONO_ADDR_W $clog2(`NONO_MEM_DEPTH)
`define NONO_HDR_TAG 16'h8000      // marks a header word, options never reach bit 15

// host side flow control
`define NONO_BYTE_CREDITS 8

`endif
